// ==== tb.f ====
hdl/cordicPkg.sv
hdl/imagePkg.sv
hdl/rotateCtrl.sv
hdl/blockPointGen.sv
hdl/cordicRotator.sv
hdl/frameBuffer.sv
hdl/rotImageTop.sv
tb/rotImage_chk.sv
tb/rotImageTb.sv

// ==== Bender.yml ====
package:
  name: rot_image

sources:
  - files:
      - hdl/cordicPkg.sv
      - hdl/imagePkg.sv
      - hdl/rotateCtrl.sv
      - hdl/blockPointGen.sv
      - hdl/cordicRotator.sv
      - hdl/frameBuffer.sv
      - hdl/rotImageTop.sv
  - target: test
    files:
      - tb/rotImage_chk.sv
      - tb/rotImageTb.sv

// ==== tb/rotImageTb.sv ====
//==========================================================================
// Bitmap rotation testbench
//==========================================================================
`timescale 1ns/1ps

module rotImageTb;
	import cordicPkg::*;
	import imagePkg::*;

	// clocks from the start edge to done_o
	localparam int DONE_CYCLES = NUM_POINTS + ROT_LATENCY + 3;
	localparam int TIMEOUT = 2000;

	logic   clk;
	logic   reset;
	logic   start_i;
	angleT  theta_i;
	rowIdxT lineSel_i;
	lineT   lineData_o;
	logic   done_o;

	lineT expFrame [0:IMG_SIZE-1];
	int   errCount = 0;
	int   checkCount = 0;
	int   testCount = 0;
	int   testErrBase = 0;
	logic cmpReq = 1'b0;
	int   cmpFirst;
	int   cmpLast;

	rotImageTop dut0 (
		.clk        (clk),
		.reset      (reset),
		.start_i    (start_i),
		.theta_i    (theta_i),
		.lineSel_i  (lineSel_i),
		.lineData_o (lineData_o),
		.done_o     (done_o)
	);

	bind rotImageTop rotImageChk chk0 (
		.clk        (clk),
		.reset      (reset),
		.start_i    (start_i),
		.busy_i     (ctrl0.busy),
		.done_i     (done_o),
		.lineData_i (lineData_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic checkValue(string name, lineT got, lineT exp);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	task automatic abortRun(string why);
		$display("%s", why);
		$display("Errors found");
		$finish;
	endtask

	// expected frame after centering, gain, 11 CORDIC iterations and rounding
	function automatic void modelFrame(angleT theta);
		coordT x;
		coordT y;
		coordT tx;
		int    ang;
		int    px;
		int    py;
		foreach (expFrame[r]) expFrame[r] = '0;
		for (int b = 0; b < NUM_BLOCKS; b++) begin
			for (int dx = 0; dx < BLOCK_SIDE; dx++) begin
				for (int dy = 0; dy < BLOCK_SIDE; dy++) begin
					x = coordT'((int'(BLOCK_ORIGINS[b].x) + dx - CENTER) <<< COORD_FRAC);
					y = coordT'((int'(BLOCK_ORIGINS[b].y) + dy - CENTER) <<< COORD_FRAC);
					x = coordT'((int'(x) * GAIN_COMP) >>> 10);
					y = coordT'((int'(y) * GAIN_COMP) >>> 10);
					ang = int'(theta);
					for (int i = 0; i < NUM_STAGES; i++) begin
						if (ang >= 0) begin
							tx = x - (y >>> i);
							y = y + (x >>> i);
							ang = ang - int'(ATAN_TABLE[i]);
						end else begin
							tx = x + (y >>> i);
							y = y - (x >>> i);
							ang = ang + int'(ATAN_TABLE[i]);
						end
						x = tx;
					end
					tx = x + coordT'(1 << (COORD_FRAC - 1));
					px = int'(tx >>> COORD_FRAC) + CENTER;
					tx = y + coordT'(1 << (COORD_FRAC - 1));
					py = int'(tx >>> COORD_FRAC) + CENTER;
					if (px >= 0 && px < IMG_SIZE && py >= 0 && py < IMG_SIZE) begin
						expFrame[py][px] = 1'b1;
					end
				end
			end
		end
	endfunction

	// reads rows cmpFirst to cmpLast on request
	initial begin : compareProc
		lineT exp;
		forever begin
			@(posedge clk);
			if (cmpReq) begin
				for (int r = cmpFirst; r <= cmpLast; r++) begin
					@(negedge clk);
					lineSel_i = rowIdxT'(r);
					@(negedge clk);
					exp = (r < IMG_SIZE) ? expFrame[r] : '0;
					checkValue($sformatf("lineData_o[%0d]", r), lineData_o, exp);
				end
				cmpReq = 1'b0;
			end
		end
	end

	task automatic compareRows(int first, int last);
		int n;
		cmpFirst = first;
		cmpLast = last;
		cmpReq = 1'b1;
		n = 0;
		while (cmpReq && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (cmpReq) abortRun("frame readback did not finish in time");
		@(negedge clk);
	endtask

	// one run with an optional second start pulse at clock midCycle
	task automatic runRotation(angleT theta, int midCycle, angleT midTheta);
		int k;
		theta_i = theta;
		start_i = 1'b1;
		@(negedge clk);
		start_i = 1'b0;
		k = 0;
		while (!done_o && k < TIMEOUT) begin
			if (k == midCycle) begin
				start_i = 1'b1;
				theta_i = midTheta;
			end else begin
				start_i = 1'b0;
			end
			@(negedge clk);
			k++;
		end
		if (!done_o) abortRun("done_o never rose after start_i");
		checkValue("done_o latency", lineT'(k), lineT'(DONE_CYCLES));
	endtask

	task automatic endTest(string name);
		testCount++;
		if (errCount == testErrBase) begin
			$display("test %0d %s: ok", testCount, name);
		end else begin
			$display("test %0d %s: %0d mismatches", testCount, name, errCount - testErrBase);
		end
		testErrBase = errCount;
	endtask

	task automatic checkAngle(angleT theta);
		modelFrame(theta);
		runRotation(theta, -1, '0);
		compareRows(0, IMG_SIZE - 1);
		endTest($sformatf("theta=%0d", theta));
	endtask

	initial begin
		angleT randAngle;
		void'($urandom(32'h2389_26d5));
		reset = 1'b1;
		start_i = 1'b0;
		theta_i = '0;
		lineSel_i = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		checkValue("done_o", lineT'(done_o), '0);
		foreach (expFrame[r]) expFrame[r] = '0;
		compareRows(0, IMG_SIZE - 1);
		endTest("reset state");

		checkAngle(angleT'(0));
		checkAngle(angleT'(804));
		checkAngle(angleT'(-1608));
		for (int n = 0; n < 5; n++) begin
			randAngle = angleT'(int'($urandom_range(3216, 0)) - 1608);
			checkAngle(randAngle);
		end

		// restart attempt while busy must leave the first angle in place
		modelFrame(angleT'(300));
		runRotation(angleT'(300), 150, angleT'(-900));
		compareRows(0, IMG_SIZE - 1);
		endTest("start during run ignored");

		compareRows(IMG_SIZE, 63);
		endTest("rows past frame");

		errCount += dut0.chk0.failCount;
		$display("tests=%0d checks=%0d assertFails=%0d errors=%0d",
			testCount, checkCount, dut0.chk0.failCount, errCount);
		if (errCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== tb/rotImage_chk.sv ====
//==========================================================================
// Control output assertions
//==========================================================================
`timescale 1ns/1ps

module rotImageChk (
	input logic           clk,
	input logic           reset,
	input logic           start_i,
	input logic           busy_i,
	input logic           done_i,
	input imagePkg::lineT lineData_i
);
	int failCount = 0;

	doneLowAfterReset: assert property (@(posedge clk) reset |=> !done_i)
		else begin
			$error("done_o high in the cycle after reset");
			failCount++;
		end

	// an accepted start drops done_o on the next edge
	doneFallsOnStart: assert property (@(posedge clk) disable iff (reset)
		(start_i && !busy_i) |=> !done_i)
		else begin
			$error("done_o still high after an accepted start");
			failCount++;
		end

	lineDataKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(lineData_i))
		else begin
			$error("lineData_o has unknown bits");
			failCount++;
		end

endmodule

// ==== hdl/rotImageTop.sv ====
//==========================================================================
// Bitmap rotation top level
//==========================================================================
`timescale 1ns/1ps

module rotImageTop (
	input  logic             clk,
	input  logic             reset,
	input  logic             start_i,
	input  cordicPkg::angleT theta_i,
	input  imagePkg::rowIdxT lineSel_i,
	output imagePkg::lineT   lineData_o,
	output logic             done_o
);
	import cordicPkg::*;
	import imagePkg::*;

	pointIdxT pointIdx;
	logic     pointValid;
	angleT    theta;
	logic     clearFrame;
	vecT      genVec;
	logic     genValid;
	vecT      rotVec;
	logic     rotValid;

	rotateCtrl ctrl0 (
		.clk          (clk),
		.reset        (reset),
		.start_i      (start_i),
		.theta_i      (theta_i),
		.pointIdx_o   (pointIdx),
		.pointValid_o (pointValid),
		.theta_o      (theta),
		.clearFrame_o (clearFrame),
		.done_o       (done_o)
	);

	blockPointGen gen0 (
		.clk          (clk),
		.reset        (reset),
		.pointIdx_i   (pointIdx),
		.pointValid_i (pointValid),
		.vec_o        (genVec),
		.vecValid_o   (genValid)
	);

	cordicRotator rot0 (
		.clk        (clk),
		.reset      (reset),
		.vec_i      (genVec),
		.vecValid_i (genValid),
		.theta_i    (theta),
		.vec_o      (rotVec),
		.vecValid_o (rotValid)
	);

	frameBuffer fb0 (
		.clk        (clk),
		.reset      (reset),
		.clear_i    (clearFrame),
		.vec_i      (rotVec),
		.vecValid_i (rotValid),
		.lineSel_i  (lineSel_i),
		.lineData_o (lineData_o)
	);

endmodule

// ==== hdl/frameBuffer.sv ====
//==========================================================================
// Rotated point rasterizer and frame store
//==========================================================================
`timescale 1ns/1ps

module frameBuffer (
	input  logic             clk,
	input  logic             reset,
	input  logic             clear_i,
	input  cordicPkg::vecT   vec_i,
	input  logic             vecValid_i,
	input  imagePkg::rowIdxT lineSel_i,
	output imagePkg::lineT   lineData_o
);
	import cordicPkg::*;
	import imagePkg::*;

	localparam coordT HALF_PIXEL = coordT'(1 << (COORD_FRAC - 1));

	lineT  frame [0:IMG_SIZE-1];
	coordT pixX;
	coordT pixY;
	logic  inFrame;

	// round to nearest pixel, then move the origin back to the corner
	assign pixX = ((vec_i.x + HALF_PIXEL) >>> COORD_FRAC) + coordT'(CENTER);
	assign pixY = ((vec_i.y + HALF_PIXEL) >>> COORD_FRAC) + coordT'(CENTER);

	// points rotated off the frame are dropped
	assign inFrame = (pixX >= 0) && (pixX < IMG_SIZE) && (pixY >= 0) && (pixY < IMG_SIZE);

	always_ff @(posedge clk) begin
		if (reset || clear_i) begin
			for (int r = 0; r < IMG_SIZE; r++) begin
				frame[r] <= '0;
			end
		end else if (vecValid_i && inFrame) begin
			frame[pixY[ROW_W-1:0]][pixX[ROW_W-1:0]] <= 1'b1;
		end
	end

	// rows past the frame read as zero
	always_ff @(posedge clk) begin
		if (reset) begin
			lineData_o <= '0;
		end else if (lineSel_i < IMG_SIZE) begin
			lineData_o <= frame[lineSel_i];
		end else begin
			lineData_o <= '0;
		end
	end

endmodule

// ==== hdl/cordicRotator.sv ====
//==========================================================================
// Pipelined CORDIC vector rotator
//==========================================================================
`timescale 1ns/1ps

module cordicRotator (
	input  logic             clk,
	input  logic             reset,
	input  cordicPkg::vecT   vec_i,
	input  logic             vecValid_i,
	input  cordicPkg::angleT theta_i,
	output cordicPkg::vecT   vec_o,
	output logic             vecValid_o
);
	import cordicPkg::*;

	// entry 0 is the gain register, entry i+1 the result of iteration i
	vecT   stVec   [0:NUM_STAGES];
	angleT stAngle [0:NUM_STAGES];
	logic  stValid [0:NUM_STAGES];

	// pre-scale by 1/K so the output keeps the input magnitude
	function automatic coordT gainScale(coordT c);
		logic signed [2*COORD_W-1:0] prod;
		prod = c * GAIN_COMP;
		return coordT'(prod >>> GAIN_FRAC);
	endfunction

	always_ff @(posedge clk) begin
		stVec[0].x <= gainScale(vec_i.x);
		stVec[0].y <= gainScale(vec_i.y);
		stAngle[0] <= theta_i;
		if (reset) begin
			stValid[0] <= 1'b0;
		end else begin
			stValid[0] <= vecValid_i;
		end
	end

	for (genvar i = 0; i < NUM_STAGES; i++) begin : gStage
		coordT xShift;
		coordT yShift;

		assign xShift = stVec[i].x >>> i;
		assign yShift = stVec[i].y >>> i;

		always_ff @(posedge clk) begin
			// drive the residual angle towards zero
			if (stAngle[i] >= 0) begin
				stVec[i+1].x <= stVec[i].x - yShift;
				stVec[i+1].y <= stVec[i].y + xShift;
				stAngle[i+1] <= stAngle[i] - ATAN_TABLE[i];
			end else begin
				stVec[i+1].x <= stVec[i].x + yShift;
				stVec[i+1].y <= stVec[i].y - xShift;
				stAngle[i+1] <= stAngle[i] + ATAN_TABLE[i];
			end
			if (reset) begin
				stValid[i+1] <= 1'b0;
			end else begin
				stValid[i+1] <= stValid[i];
			end
		end
	end

	assign vec_o = stVec[NUM_STAGES];
	assign vecValid_o = stValid[NUM_STAGES];

endmodule

// ==== hdl/blockPointGen.sv ====
//==========================================================================
// Shape point generator
//==========================================================================
`timescale 1ns/1ps

module blockPointGen (
	input  logic               clk,
	input  logic               reset,
	input  imagePkg::pointIdxT pointIdx_i,
	input  logic               pointValid_i,
	output cordicPkg::vecT     vec_o,
	output logic               vecValid_o
);
	import cordicPkg::*;
	import imagePkg::*;

	localparam int OFF_W = $clog2(BLOCK_SIDE);

	logic [$bits(pointIdxT)-2*OFF_W-1:0] blockNum;
	logic [OFF_W-1:0] offX;
	logic [OFF_W-1:0] offY;
	pixelT origin;

	// pixel relative to the pivot, scaled to fixed point
	function automatic coordT toFixed(rowIdxT base, logic [OFF_W-1:0] off);
		coordT pix;
		pix = coordT'(base) + coordT'(off) - coordT'(CENTER);
		return pix <<< COORD_FRAC;
	endfunction

	// index is block, then column within block, then row
	assign blockNum = pointIdx_i[$bits(pointIdxT)-1:2*OFF_W];
	assign offX = pointIdx_i[2*OFF_W-1:OFF_W];
	assign offY = pointIdx_i[OFF_W-1:0];
	assign origin = BLOCK_ORIGINS[blockNum];

	always_ff @(posedge clk) begin
		vec_o.x <= toFixed(origin.x, offX);
		vec_o.y <= toFixed(origin.y, offY);
		if (reset) begin
			vecValid_o <= 1'b0;
		end else begin
			vecValid_o <= pointValid_i;
		end
	end

endmodule

// ==== hdl/rotateCtrl.sv ====
//==========================================================================
// Rotation run sequencer
//==========================================================================
`timescale 1ns/1ps

module rotateCtrl (
	input  logic               clk,
	input  logic               reset,
	input  logic               start_i,
	input  cordicPkg::angleT   theta_i,
	output imagePkg::pointIdxT pointIdx_o,
	output logic               pointValid_o,
	output cordicPkg::angleT   theta_o,
	output logic               clearFrame_o,
	output logic               done_o
);
	import cordicPkg::*;
	import imagePkg::*;

	// point generator, rotator and frame write behind the last index
	localparam int DRAIN_CYCLES = ROT_LATENCY + 2;
	localparam int DRAIN_W = $clog2(DRAIN_CYCLES + 1);

	logic               busy;
	logic [DRAIN_W-1:0] drainCnt;
	logic               startOk;

	// starts during a run are dropped
	assign startOk = start_i && !busy;

	// angle held for the whole run
	always_ff @(posedge clk) begin
		if (startOk) begin
			theta_o <= theta_i;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			pointValid_o <= 1'b0;
			pointIdx_o <= '0;
			drainCnt <= '0;
			clearFrame_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			clearFrame_o <= startOk;
			if (startOk) begin
				busy <= 1'b1;
				pointValid_o <= 1'b1;
				pointIdx_o <= '0;
				drainCnt <= '0;
				done_o <= 1'b0;
			end else if (pointValid_o) begin
				// one index per clock
				if (pointIdx_o == pointIdxT'(NUM_POINTS - 1)) begin
					pointValid_o <= 1'b0;
				end else begin
					pointIdx_o <= pointIdx_o + 1'b1;
				end
			end else if (busy) begin
				if (drainCnt == DRAIN_W'(DRAIN_CYCLES)) begin
					busy <= 1'b0;
					done_o <= 1'b1;
				end else begin
					drainCnt <= drainCnt + 1'b1;
				end
			end
		end
	end

endmodule

// ==== hdl/imagePkg.sv ====
//==========================================================================
// Frame geometry and shape table
//==========================================================================

package imagePkg;

	localparam int IMG_SIZE = 47;
	// rotation pivot, in pixels
	localparam int CENTER = 23;
	localparam int ROW_W = 6;

	// bit c is column c
	typedef logic [IMG_SIZE-1:0] lineT;
	typedef logic [ROW_W-1:0] rowIdxT;

	typedef struct packed {
		rowIdxT x;
		rowIdxT y;
	} pixelT;

	localparam int NUM_BLOCKS = 26;
	localparam int BLOCK_SIDE = 4;
	localparam int NUM_POINTS = NUM_BLOCKS * BLOCK_SIDE * BLOCK_SIDE;

	typedef logic [$clog2(NUM_POINTS)-1:0] pointIdxT;

	// top-left corner of each 4x4 block
	localparam pixelT BLOCK_ORIGINS [0:NUM_BLOCKS-1] = '{
		'{8, 6},
		'{36, 6},
		'{12, 10},
		'{16, 10},
		'{28, 10},
		'{32, 10},
		'{16, 14},
		'{20, 14},
		'{24, 14},
		'{28, 14},
		'{12, 18},
		'{16, 18},
		'{28, 18},
		'{32, 18},
		'{16, 22},
		'{28, 22},
		'{12, 26},
		'{16, 26},
		'{28, 26},
		'{32, 26},
		'{16, 30},
		'{20, 30},
		'{24, 30},
		'{28, 30},
		'{12, 34},
		'{32, 34}
	};

endpackage

// ==== hdl/cordicPkg.sv ====
//==========================================================================
// CORDIC rotator formats and constants
//==========================================================================

package cordicPkg;

	// coordinates are signed with 8 fraction bits
	localparam int COORD_W = 16;
	localparam int COORD_FRAC = 8;

	typedef logic signed [COORD_W-1:0] coordT;

	// one point of the shape
	typedef struct packed {
		coordT x;
		coordT y;
	} vecT;

	// angle in radians with 10 fraction bits
	// legal range is +/-1608 or +/-pi/2
	localparam int ANGLE_W = 13;
	localparam int ANGLE_FRAC = 10;

	typedef logic signed [ANGLE_W-1:0] angleT;

	localparam int NUM_STAGES = 11;

	// atan(2^-i) in angle units
	localparam angleT ATAN_TABLE [0:NUM_STAGES-1] = '{
		804, 475, 251, 127, 64, 32, 16, 8, 4, 2, 1
	};

	// 1/K for 11 iterations in the angle's fraction width
	localparam int GAIN_COMP = 622;
	localparam int GAIN_FRAC = ANGLE_FRAC;

	// gain register plus one register per iteration
	localparam int ROT_LATENCY = NUM_STAGES + 1;

endpackage
